//--- verilog/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Memory geometry in 32-bit words
`define MEM_DEPTH 256

// Word index width, enough to address MEM_DEPTH words
`define MEM_IDX_W 8

// AXI response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

// Largest SRAM response delay in cycles
`define SRAM_MAX_LAT 4

`endif

//--- verilog/mem_pkg.sv
package mem_pkg;

    // Byte address on the AXI side
    typedef logic [31:0] addr_t;

    // One data word
    typedef logic [31:0] data_t;

    // One strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // AXI response code
    typedef logic [1:0] resp_t;

    // Slave FSM, one transaction in flight at a time
    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } slave_state_t;

endpackage

//--- verilog/axi_lite_slave.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module axi_lite_slave import mem_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // Write address channel
    input  addr_t  awaddr,
    input  logic   awvalid,
    output logic   awready,

    // Write data channel
    input  data_t  wdata,
    input  strb_t  wstrb,
    input  logic   wvalid,
    output logic   wready,

    // Write response channel
    output resp_t  bresp,
    output logic   bvalid,
    input  logic   bready,

    // Read address channel
    input  addr_t  araddr,
    input  logic   arvalid,
    output logic   arready,

    // Read data channel
    output data_t  rdata,
    output resp_t  rresp,
    output logic   rvalid,
    input  logic   rready,

    // SRAM request side
    output logic   rd_req,
    output addr_t  rd_addr,
    output logic   wt_req,
    output addr_t  wt_addr,
    output data_t  wt_data,
    output strb_t  wt_strb,

    // SRAM completion side
    input  data_t  rd_data,
    input  logic   rd_err,
    input  logic   rd_done,
    input  logic   wt_err,
    input  logic   wt_done
);

    slave_state_t state;

    logic resp_pending;
    logic accept_rd;
    logic accept_wr;
    logic finish_rd;
    logic finish_wr;

    // No new address while a B or R response is still waiting
    assign resp_pending = bvalid || rvalid;

    // Reads win when both kinds are offered in the same cycle
    assign accept_rd = (state == IDLE) && !resp_pending && arvalid;
    assign accept_wr = (state == IDLE) && !resp_pending && !arvalid &&
                       awvalid && wvalid;

    assign finish_rd = (state == READ) && rd_done;
    assign finish_wr = (state == WRITE) && wt_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            rd_req  <= 1'b0;
            wt_req  <= 1'b0;
        end else begin
            // Ready outputs are single-cycle pulses
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;

            // Response handshakes complete
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (accept_rd) begin
                        arready <= 1'b1;
                        state   <= READ;
                    end else if (accept_wr) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        state   <= WRITE;
                    end
                end

                READ: begin
                    // Hold the request level until the SRAM reports done
                    if (rd_done) begin
                        rd_req <= 1'b0;
                        rvalid <= 1'b1;
                        state  <= IDLE;
                    end else begin
                        rd_req <= 1'b1;
                    end
                end

                WRITE: begin
                    if (wt_done) begin
                        wt_req <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= IDLE;
                    end else begin
                        wt_req <= 1'b1;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request fields and response payload
    always_ff @(posedge clk) begin
        if (accept_rd) begin
            rd_addr <= araddr;
        end
        if (accept_wr) begin
            wt_addr <= awaddr;
            wt_data <= wdata;
            wt_strb <= wstrb;
        end
        if (finish_rd) begin
            rdata <= rd_data;
            rresp <= rd_err ? `RESP_SLVERR : `RESP_OKAY;
        end
        if (finish_wr) begin
            bresp <= wt_err ? `RESP_SLVERR : `RESP_OKAY;
        end
    end

endmodule

//--- verilog/sram_ctrl.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module sram_ctrl import mem_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // Read request and completion
    input  logic   rd_req,
    input  addr_t  rd_addr,
    output data_t  rd_data,
    output logic   rd_err,
    output logic   rd_done,

    // Write request and completion
    input  logic   wt_req,
    input  addr_t  wt_addr,
    input  data_t  wt_data,
    input  strb_t  wt_strb,
    output logic   wt_err,
    output logic   wt_done
);

    localparam int LAT_W = $clog2(`SRAM_MAX_LAT + 1);
    localparam logic [7:0] LFSR_SEED = 8'hb5;

    data_t mem [`MEM_DEPTH];

    logic [7:0]            lfsr;
    logic                  busy;
    logic                  op_write;
    logic [LAT_W-1:0]      cnt;
    logic [LAT_W-1:0]      pick_lat;
    logic                  start;
    logic                  finish;
    addr_t                 req_addr;
    logic                  in_range;
    logic [`MEM_IDX_W-1:0] idx;

    // A request still high during its own done pulse is the one just served
    assign start  = !busy && !rd_done && !wt_done && (rd_req || wt_req);
    assign finish = busy && (cnt == LAT_W'(1));

    // Delay of 1 to SRAM_MAX_LAT cycles
    assign pick_lat = LAT_W'(lfsr % `SRAM_MAX_LAT) + LAT_W'(1);

    assign req_addr = op_write ? wt_addr : rd_addr;

    // Low two bits are the byte offset and are ignored
    assign in_range = req_addr[31:2] < 30'(`MEM_DEPTH);
    assign idx      = req_addr[`MEM_IDX_W+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr     <= LFSR_SEED;
            busy     <= 1'b0;
            op_write <= 1'b0;
            cnt      <= '0;
            rd_done  <= 1'b0;
            wt_done  <= 1'b0;
            rd_err   <= 1'b0;
            wt_err   <= 1'b0;
        end else begin
            // x^8 + x^6 + x^5 + x^4 + 1, free running
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};

            rd_done <= 1'b0;
            wt_done <= 1'b0;

            if (start) begin
                busy     <= 1'b1;
                op_write <= wt_req;
                cnt      <= pick_lat;
            end else if (finish) begin
                busy <= 1'b0;
                if (op_write) begin
                    wt_done <= 1'b1;
                    wt_err  <= !in_range;
                end else begin
                    rd_done <= 1'b1;
                    rd_err  <= !in_range;
                end
            end else if (busy) begin
                cnt <= cnt - LAT_W'(1);
            end
        end
    end

    // Array access happens on the edge that raises the done pulse
    always_ff @(posedge clk) begin
        if (finish && !op_write) begin
            rd_data <= in_range ? mem[idx] : '0;
        end
        if (finish && op_write && in_range) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wt_strb[b]) begin
                    mem[idx][8*b +: 8] <= wt_data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- verilog/mem_top.sv
`timescale 1ns/100ps

module mem_top import mem_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    // Write address channel
    input  addr_t  awaddr,
    input  logic   awvalid,
    output logic   awready,

    // Write data channel
    input  data_t  wdata,
    input  strb_t  wstrb,
    input  logic   wvalid,
    output logic   wready,

    // Write response channel
    output resp_t  bresp,
    output logic   bvalid,
    input  logic   bready,

    // Read address channel
    input  addr_t  araddr,
    input  logic   arvalid,
    output logic   arready,

    // Read data channel
    output data_t  rdata,
    output resp_t  rresp,
    output logic   rvalid,
    input  logic   rready
);

    // Slave to SRAM controller
    logic  rd_req;
    addr_t rd_addr;
    data_t rd_data;
    logic  rd_err;
    logic  rd_done;
    logic  wt_req;
    addr_t wt_addr;
    data_t wt_data;
    strb_t wt_strb;
    logic  wt_err;
    logic  wt_done;

    axi_lite_slave slave_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .wt_req  (wt_req),
        .wt_addr (wt_addr),
        .wt_data (wt_data),
        .wt_strb (wt_strb),
        .rd_data (rd_data),
        .rd_err  (rd_err),
        .rd_done (rd_done),
        .wt_err  (wt_err),
        .wt_done (wt_done)
    );

    sram_ctrl sram_i (
        .clk     (clk),
        .rst     (rst),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_err  (rd_err),
        .rd_done (rd_done),
        .wt_req  (wt_req),
        .wt_addr (wt_addr),
        .wt_data (wt_data),
        .wt_strb (wt_strb),
        .wt_err  (wt_err),
        .wt_done (wt_done)
    );

endmodule

//--- sim/mem_assertions.sv
`timescale 1ns/100ps

module mem_assertions import mem_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  awready,
    input logic  arready,
    input logic  bvalid,
    input logic  bready,
    input resp_t bresp,
    input logic  rvalid,
    input logic  rready,
    input data_t rdata,
    input resp_t rresp,
    input logic  rd_req,
    input logic  wt_req
);

    // Assertion failures seen so far, read by the testbench at the end
    int failures = 0;

    // A response holds with a stable payload until its ready is seen
    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            failures++;
            $error("bvalid or bresp changed before bready");
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            failures++;
            $error("rvalid, rdata or rresp changed before rready");
        end

    ready_excl: assert property (@(posedge clk) disable iff (rst) !(arready && awready))
        else begin
            failures++;
            $error("arready and awready high together");
        end

    // Pending response blocks the next address
    no_accept: assert property (@(posedge clk) disable iff (rst)
        bvalid || rvalid |=> !arready && !awready)
        else begin
            failures++;
            $error("address accepted while a response was pending");
        end

    req_excl: assert property (@(posedge clk) disable iff (rst) !(rd_req && wt_req))
        else begin
            failures++;
            $error("rd_req and wt_req high together");
        end

endmodule

//--- sim/tb_mem_top.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module tb_mem_top import mem_pkg::*; ();

    localparam int MAX_DELAY = 8;
    localparam int WAIT_LIMIT = 64;
    // Fill and readback, strobes, range, priority, back-pressure, stream
    localparam int TXN_COUNT = 272 + 64 + 24 + 6 + 16 + 200;
    localparam int WATCHDOG_CYCLES = TXN_COUNT * (`SRAM_MAX_LAT + 10 + MAX_DELAY) + 500;

    logic clk = 1'b0;
    logic rst;
    addr_t awaddr;
    addr_t araddr;
    data_t wdata;
    strb_t wstrb;
    data_t rdata;
    resp_t bresp;
    resp_t rresp;
    logic awvalid;
    logic awready;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    logic arvalid;
    logic arready;
    logic rvalid;
    logic rready;

    data_t model [`MEM_DEPTH];
    logic [31:0] lcg_state = 32'ha3ca;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    mem_top dut_i (.*);

    bind axi_lite_slave mem_assertions assert_i (
        .clk     (clk),
        .rst     (rst),
        .awready (awready),
        .arready (arready),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rd_req  (rd_req),
        .wt_req  (wt_req)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic addr_t rand_addr_in();
        logic [31:0] r;
        r = lcg_next();
        return addr_t'((r >> 8) % `MEM_DEPTH) * 4 + addr_t'(r[1:0]);
    endfunction

    // Bit 10 set puts the word index at MEM_DEPTH or above
    function automatic addr_t rand_addr_out();
        return lcg_next() | 32'h0000_0400;
    endfunction

    // Word index is the byte address over four
    function automatic logic addr_ok(addr_t addr);
        return (addr >> 2) < 32'(`MEM_DEPTH);
    endfunction

    function automatic data_t byte_merge(data_t old, data_t wr, strb_t strb);
        data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (wr & mask);
    endfunction

    function automatic logic resp_valid(logic is_read);
        return is_read ? rvalid : bvalid;
    endfunction

    task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%08h, got 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    // Wait for the ready pulse of the offered address, then drop the valids
    task automatic wait_accept(logic is_read);
        int n;
        n = 0;
        @(negedge clk);
        while (!(is_read ? arready : awready) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!(is_read ? arready : awready)) begin
            $display("No ready pulse for the %s address", is_read ? "read" : "write");
            errors++;
        end else if (!is_read) begin
            check_eq("wready", 32'h1, 32'(wready));
        end
        @(posedge clk);
        if (is_read) begin
            arvalid <= 1'b0;
        end else begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end
    endtask

    // Stall the response for delay cycles, then take it
    task automatic take_response(logic is_read, int delay, output data_t data,
                                 output resp_t resp);
        int n;
        n = 0;
        data = '0;
        @(negedge clk);
        while (!resp_valid(is_read) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!resp_valid(is_read)) begin
            $display("No %s response arrived in time", is_read ? "read" : "write");
            errors++;
        end
        if (is_read) begin
            data = rdata;
        end
        resp = is_read ? rresp : bresp;
        repeat (delay) begin
            @(negedge clk);
            if (!resp_valid(is_read)) begin
                $display("The %s response dropped before it was taken",
                         is_read ? "read" : "write");
                errors++;
            end
            if (is_read) begin
                check_eq("rdata", data, rdata);
                check_eq("rresp", 32'(resp), 32'(rresp));
            end else begin
                check_eq("bresp", 32'(resp), 32'(bresp));
            end
            if (arready || awready) begin
                $display("An address was accepted while a response was pending");
                errors++;
            end
        end
        @(posedge clk);
        if (is_read) begin
            rready <= 1'b1;
        end else begin
            bready <= 1'b1;
        end
        @(posedge clk);
        rready <= 1'b0;
        bready <= 1'b0;
    endtask

    task automatic axi_write(addr_t addr, data_t data, strb_t strb, int delay);
        data_t unused_data;
        resp_t resp;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        wait_accept(1'b0);
        take_response(1'b0, delay, unused_data, resp);
        check_eq("bresp", 32'(addr_ok(addr) ? `RESP_OKAY : `RESP_SLVERR), 32'(resp));
        if (addr_ok(addr)) begin
            model[addr[`MEM_IDX_W+1:2]] = byte_merge(model[addr[`MEM_IDX_W+1:2]], data, strb);
        end
    endtask

    task automatic axi_read(addr_t addr, int delay);
        data_t data;
        resp_t resp;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        wait_accept(1'b1);
        take_response(1'b1, delay, data, resp);
        check_eq("rresp", 32'(addr_ok(addr) ? `RESP_OKAY : `RESP_SLVERR), 32'(resp));
        check_eq("rdata", addr_ok(addr) ? model[addr[`MEM_IDX_W+1:2]] : 32'h0, data);
    endtask

    task automatic test_reset_and_words();
        check_eq("awready", 32'h0, 32'(awready));
        check_eq("wready", 32'h0, 32'(wready));
        check_eq("arready", 32'h0, 32'(arready));
        check_eq("bvalid", 32'h0, 32'(bvalid));
        check_eq("rvalid", 32'h0, 32'(rvalid));
        // Whole array gets a pattern built from the full byte address
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            axi_write(addr_t'(i * 4), addr_t'(i * 4) * 32'h9e3779b1 ^ 32'h5a5ac3c3, 4'hf, 0);
        end
        for (int i = 0; i < 16; i++) begin
            axi_read(addr_t'(i * 68), 0);
        end
    endtask

    task automatic test_strobes();
        addr_t addr;
        for (int i = 0; i < 32; i++) begin
            addr = rand_addr_in();
            axi_write(addr, lcg_next(), strb_t'(lcg_next() >> 28), 0);
            axi_read(addr, 0);
        end
    endtask

    task automatic test_out_of_range();
        addr_t addr;
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr_out();
            axi_write(addr, lcg_next(), 4'hf, 0);
            axi_read(addr, 0);
            // Word the index would alias to without the range check
            axi_read(addr & 32'h0000_03fc, 0);
        end
    endtask

    task automatic test_read_priority();
        addr_t addr;
        data_t old_word;
        data_t new_word;
        data_t data;
        resp_t resp;
        for (int k = 0; k < 2; k++) begin
            addr = rand_addr_in();
            old_word = model[addr[`MEM_IDX_W+1:2]];
            new_word = lcg_next();
            @(posedge clk);
            araddr  <= addr;
            arvalid <= 1'b1;
            awaddr  <= addr;
            wdata   <= new_word;
            wstrb   <= 4'hf;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            wait_accept(1'b1);
            take_response(1'b1, 2, data, resp);
            check_eq("rdata", old_word, data);
            check_eq("rresp", 32'(`RESP_OKAY), 32'(resp));
            wait_accept(1'b0);
            take_response(1'b0, 1, data, resp);
            check_eq("bresp", 32'(`RESP_OKAY), 32'(resp));
            model[addr[`MEM_IDX_W+1:2]] = new_word;
            axi_read(addr, 0);
        end
    endtask

    task automatic test_back_pressure();
        addr_t addr;
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr_in();
            axi_write(addr, lcg_next(), 4'hf, int'(lcg_next() >> 29) + 1);
            axi_read(addr, int'(lcg_next() >> 29) + 1);
        end
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        addr_t addr;
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            addr = (r[31:29] == 3'd0) ? rand_addr_out() : rand_addr_in();
            if (r[20]) begin
                axi_write(addr, lcg_next(), strb_t'(lcg_next() >> 28), int'(r[15:13]));
            end else begin
                axi_read(addr, int'(r[15:13]));
            end
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int mark;
        rst     <= 1'b1;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        mark = errors;
        test_reset_and_words();
        finish_test("reset and full words", mark);
        mark = errors;
        test_strobes();
        finish_test("byte strobes", mark);
        mark = errors;
        test_out_of_range();
        finish_test("out of range", mark);
        mark = errors;
        test_read_priority();
        finish_test("read priority", mark);
        mark = errors;
        test_back_pressure();
        finish_test("back-pressure", mark);
        mark = errors;
        test_random_stream();
        finish_test("random stream", mark);
        errors += dut_i.slave_i.assert_i.failures;
        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, dut_i.slave_i.assert_i.failures);
        if (errors == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/axi_lite_slave.sv
verilog/sram_ctrl.sv
verilog/mem_top.sv
sim/mem_assertions.sv
sim/tb_mem_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
